//--- design/sram_pkg.sv
`default_nettype none

package sram_pkg;

    // word and lane geometry
    localparam int DATA_W = 16;
    localparam int LANES  = 2; // lower and upper byte

    // host operation
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_e;

    // sequencer phases
    typedef enum logic [1:0]
    {
        ST_IDLE   = 2'd0, // waiting for cmd_start
        ST_SETUP  = 2'd1, // chip selected, address stable
        ST_ACCESS = 2'd2, // we_n or oe_n low with lane strobes
        ST_DONE   = 2'd3  // strobes released, result reported
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- design/sram_bus_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sram_bus_if
    import sram_pkg::*;
#(
    parameter int ADDR_W = 8
);

    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] dq_wr;   // write half of the data pins
    logic [DATA_W-1:0] dq_rd;   // read half, zero when not driven
    logic              ce_n;
    logic              we_n;
    logic              oe_n;
    logic              lb_n;    // lower byte lane
    logic              ub_n;    // upper byte lane

    modport ctrl (
        output addr, dq_wr, ce_n, we_n, oe_n, lb_n, ub_n,
        input  dq_rd
    );

    modport mem (
        input  addr, dq_wr, ce_n, we_n, oe_n, lb_n, ub_n,
        output dq_rd
    );

endinterface

`default_nettype wire

//--- design/sram_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sram_cfg_regs
    import sram_pkg::*;
#(
    parameter int ADDR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_load,     // one-cycle load pulse
    input  logic [ADDR_W-1:0] cfg_ptr,
    input  logic              auto_inc,     // level from host
    input  logic              access_done,  // from sequencer
    output logic [ADDR_W-1:0] ptr
);

    logic auto_inc_q;

    // host level sampled once per cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            auto_inc_q <= 1'b0;
        end
        else
        begin
            auto_inc_q <= auto_inc;
        end
    end

    // word pointer
    // a load in the same cycle as access_done takes priority
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ptr <= '0;
        end
        else if (cfg_load)
        begin
            ptr <= cfg_ptr;
        end
        else if (access_done && auto_inc_q)
        begin
            ptr <= ptr + 1'b1; // wraps at the top of the array
        end
    end

endmodule

`default_nettype wire

//--- design/sram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module sram_ctrl
    import sram_pkg::*;
#(
    parameter int ADDR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_start,    // ignored while busy
    input  op_e               cmd_op,
    input  logic [LANES-1:0]  byte_en,      // bit 0 lower lane, bit 1 upper lane
    input  logic [DATA_W-1:0] wdata,
    input  logic [ADDR_W-1:0] ptr,
    output logic              busy,
    output logic              rd_valid,
    output logic [DATA_W-1:0] rdata,
    output logic              access_done,
    sram_bus_if.ctrl          mem
);

    ctrl_state_e      state;
    op_e              op_q;
    logic [LANES-1:0] byte_en_q;
    logic             accept;

    assign accept = (state == ST_IDLE) && cmd_start;

    // status straight from the state register
    assign busy        = (state != ST_IDLE);
    assign access_done = (state == ST_DONE);
    assign rd_valid    = (state == ST_DONE) && (op_q == OP_READ);

    // phase sequencing and strobes
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            mem.ce_n <= 1'b1;
            mem.we_n <= 1'b1;
            mem.oe_n <= 1'b1;
            mem.lb_n <= 1'b1;
            mem.ub_n <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (cmd_start)
                    begin
                        state    <= ST_SETUP;
                        mem.ce_n <= 1'b0; // select chip, address goes out with it
                    end
                end
                ST_SETUP:
                begin
                    state    <= ST_ACCESS;
                    mem.we_n <= (op_q != OP_WRITE);
                    mem.oe_n <= (op_q != OP_READ);
                    mem.lb_n <= ~byte_en_q[0];
                    mem.ub_n <= ~byte_en_q[1];
                end
                ST_ACCESS:
                begin
                    // array stores or read word is taken on this edge
                    state    <= ST_DONE;
                    mem.ce_n <= 1'b1;
                    mem.we_n <= 1'b1;
                    mem.oe_n <= 1'b1;
                    mem.lb_n <= 1'b1;
                    mem.ub_n <= 1'b1;
                end
                ST_DONE:
                begin
                    state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // command payload and read capture
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q      <= cmd_op;
            byte_en_q <= byte_en;
            mem.addr  <= ptr;
            mem.dq_wr <= wdata;
        end
        if ((state == ST_ACCESS) && (op_q == OP_READ))
        begin
            rdata <= mem.dq_rd; // disabled lanes already zero
        end
    end

endmodule

`default_nettype wire

//--- design/sram_array.sv
`timescale 1ns/10ps
`default_nettype none

module sram_array
    import sram_pkg::*;
#(
    parameter int ADDR_W = 8
)
(
    input  logic    clk,
    sram_bus_if.mem mem
);

    localparam int LANE_W = DATA_W / LANES;
    localparam int DEPTH  = 2 ** ADDR_W;

    logic [DATA_W-1:0] ram [DEPTH];
    logic [LANES-1:0]  lane_n;

    assign lane_n = {mem.ub_n, mem.lb_n}; // active-low lane selects

    // contents survive reset
    always_ff @(posedge clk)
    begin
        if (!mem.ce_n && !mem.we_n)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (!lane_n[l])
                begin
                    ram[mem.addr][l*LANE_W +: LANE_W] <= mem.dq_wr[l*LANE_W +: LANE_W];
                end
            end
        end
    end

    // asynchronous read path
    // a lane that is not enabled reads zero in place of a floating bus
    always_comb
    begin
        mem.dq_rd = '0;
        if (!mem.ce_n && !mem.oe_n)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (!lane_n[l])
                begin
                    mem.dq_rd[l*LANE_W +: LANE_W] = ram[mem.addr][l*LANE_W +: LANE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sram_top.sv
`timescale 1ns/10ps
`default_nettype none

module sram_top
    import sram_pkg::*;
#(
    parameter int ADDR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_start,
    input  op_e               cmd_op,
    input  logic [LANES-1:0]  byte_en,
    input  logic [DATA_W-1:0] wdata,
    input  logic              cfg_load,
    input  logic [ADDR_W-1:0] cfg_ptr,
    input  logic              auto_inc,
    output logic              busy,
    output logic              rd_valid,
    output logic [DATA_W-1:0] rdata,
    output logic [ADDR_W-1:0] ptr
);

    logic access_done; // sequencer to pointer

    sram_bus_if #(.ADDR_W(ADDR_W)) bus ();

    sram_cfg_regs #(.ADDR_W(ADDR_W)) u_cfg (
        .clk         (clk),
        .rst         (rst),
        .cfg_load    (cfg_load),
        .cfg_ptr     (cfg_ptr),
        .auto_inc    (auto_inc),
        .access_done (access_done),
        .ptr         (ptr)
    );

    sram_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cmd_start   (cmd_start),
        .cmd_op      (cmd_op),
        .byte_en     (byte_en),
        .wdata       (wdata),
        .ptr         (ptr),
        .busy        (busy),
        .rd_valid    (rd_valid),
        .rdata       (rdata),
        .access_done (access_done),
        .mem         (bus.ctrl)
    );

    sram_array #(.ADDR_W(ADDR_W)) u_array (
        .clk (clk),
        .mem (bus.mem)
    );

endmodule

`default_nettype wire

//--- test/sram_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sram_tb
    import sram_pkg::*;
;

    localparam int ADDR_W      = 8;
    localparam int NUM_CMDS    = 72;                 // commands issued over all tests
    localparam int CYCLE_LIMIT = 8 * NUM_CMDS + 200; // plus reset, loads and idle gaps

    logic              clk;
    logic              rst;
    logic              cmd_start;
    op_e               cmd_op;
    logic [LANES-1:0]  byte_en;
    logic [DATA_W-1:0] wdata;
    logic              cfg_load;
    logic [ADDR_W-1:0] cfg_ptr;
    logic              auto_inc;
    logic              busy;
    logic              rd_valid;
    logic [DATA_W-1:0] rdata;
    logic [ADDR_W-1:0] ptr;

    logic [DATA_W-1:0] shadow [2**ADDR_W]; // expected array contents
    logic [DATA_W-1:0] expq [$];           // pending read results
    logic [DATA_W-1:0] got_word;
    logic [ADDR_W-1:0] exp_ptr;
    integer            seed;
    int                errors;
    int                checks;
    int                tests;
    int                lat_errors;
    int                rv_count;
    int                cycles;
    int                test_err0;
    int                rv_before;

    sram_top #(.ADDR_W(ADDR_W)) uut (
        .clk       (clk),
        .rst       (rst),
        .cmd_start (cmd_start),
        .cmd_op    (cmd_op),
        .byte_en   (byte_en),
        .wdata     (wdata),
        .cfg_load  (cfg_load),
        .cfg_ptr   (cfg_ptr),
        .auto_inc  (auto_inc),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rdata     (rdata),
        .ptr       (ptr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // expected read word, disabled lanes give zero
    function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a,
                                                   input logic [LANES-1:0] be);
        logic [DATA_W-1:0] w;
        w = shadow[a];
        if (!be[0])
            w[7:0] = 8'h00;
        if (!be[1])
            w[15:8] = 8'h00;
        return w;
    endfunction

    task automatic shadow_write(input logic [ADDR_W-1:0] a, input logic [LANES-1:0] be,
                                input logic [DATA_W-1:0] d);
        if (be[0])
            shadow[a][7:0] = d[7:0];
        if (be[1])
            shadow[a][15:8] = d[15:8];
    endtask

    task automatic check_ptr(input logic [ADDR_W-1:0] want);
        checks++;
        assert (ptr === want)
        else
        begin
            $display("Error at %0t: ptr %h, expected %h", $time, ptr, want);
            errors++;
        end
    endtask

    task automatic load_ptr(input logic [ADDR_W-1:0] v);
        cfg_ptr  = v;
        cfg_load = 1'b1;
        @(negedge clk);
        cfg_load = 1'b0;
        exp_ptr  = v;
        check_ptr(v);
    endtask

    // mode 0 plain, 1 extra cmd_start while busy, 2 cfg_load in the done cycle
    task automatic issue(input op_e op, input logic [LANES-1:0] be,
                         input logic [DATA_W-1:0] d, input int mode);
        int n;
        int rv_at;
        rv_at     = 0;
        cmd_op    = op;
        byte_en   = be;
        wdata     = d;
        cmd_start = 1'b1;
        if (op == OP_WRITE)
            shadow_write(exp_ptr, be, d);
        else
            expq.push_back(ref_read(exp_ptr, be));
        @(negedge clk);
        cmd_start = 1'b0;
        n = 0;
        while (busy && n < 8)
        begin
            n++;
            if (rd_valid && rv_at == 0)
                rv_at = n; // first cycle with rd_valid
            if (mode == 1 && n == 1)
                cmd_start = 1'b1; // sampled in ST_SETUP
            if (mode == 1 && n == 2)
                cmd_start = 1'b0;
            if (mode == 2 && n == 3)
                cfg_load = 1'b1;  // same edge as access_done
            @(negedge clk);
        end
        cfg_load = 1'b0;
        checks++;
        assert (n == 3)
        else
        begin
            $display("Error at %0t: busy high for %0d cycles, expected 3", $time, n);
            errors++;
            lat_errors++;
        end
        if (op == OP_READ)
        begin
            checks++;
            assert (rv_at != 0)
            else
            begin
                $display("Missing rd_valid: no read result within three cycles of the command");
                errors++;
                lat_errors++;
            end
            assert (rv_at == 0 || rv_at == 3)
            else
            begin
                $display("Error at %0t: rd_valid in cycle %0d, expected 3", $time, rv_at);
                errors++;
                lat_errors++;
            end
        end
        if (mode == 2)
            exp_ptr = cfg_ptr;
        else if (auto_inc)
            exp_ptr = exp_ptr + 1'b1;
        check_ptr(exp_ptr);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_err0)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    // every rd_valid must match the oldest pending read
    always @(negedge clk)
    begin
        if (!rst && rd_valid)
        begin
            rv_count++;
            checks++;
            assert (expq.size() != 0)
            else
            begin
                $display("Unexpected rd_valid: a read result arrived with no read pending");
                errors++;
            end
            if (expq.size() != 0)
            begin
                got_word = expq.pop_front();
                assert (rdata === got_word)
                else
                begin
                    $display("Error at %0t: rdata %h, expected %h", $time, rdata, got_word);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        seed      = 32'hc851_ad6c;
        rst       = 1'b1;
        cmd_start = 1'b0;
        cmd_op    = OP_READ;
        byte_en   = '0;
        wdata     = '0;
        cfg_load  = 1'b0;
        cfg_ptr   = '0;
        auto_inc  = 1'b0;
        exp_ptr   = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        checks++;
        assert (busy === 1'b0 && rd_valid === 1'b0)
        else
        begin
            $display("Error at %0t: busy %b rd_valid %b after reset", $time, busy, rd_valid);
            errors++;
        end
        check_ptr('0);
        end_test("reset");

        auto_inc = 1'b1;
        load_ptr('0); // also lets auto_inc settle
        for (int i = 0; i < 32; i++)
            issue(OP_WRITE, 2'b11, $random(seed), 0);
        check_ptr(8'd32);
        load_ptr('0);
        for (int i = 0; i < 32; i++)
            issue(OP_READ, 2'b11, '0, 0);
        end_test("sequential fill");

        auto_inc = 1'b0;
        load_ptr(8'h80);
        issue(OP_WRITE, 2'b01, 16'h12a5, 0); // lower lane only
        issue(OP_WRITE, 2'b10, 16'hc33c, 0); // upper lane only
        issue(OP_READ, 2'b11, '0, 0);
        issue(OP_READ, 2'b01, '0, 0);
        issue(OP_READ, 2'b10, '0, 0);
        check_ptr(8'h80);
        end_test("byte lanes");

        auto_inc = 1'b1;
        load_ptr(8'd5);
        rv_before = rv_count;
        issue(OP_READ, 2'b11, '0, 1);
        repeat (4) @(negedge clk);
        checks++;
        assert (rv_count == rv_before + 1)
        else
        begin
            $display("Error at %0t: %0d read results, expected 1", $time, rv_count - rv_before);
            errors++;
        end
        check_ptr(8'd6);
        end_test("ignored command");

        load_ptr(8'd10);
        cfg_ptr = 8'hc3;
        issue(OP_WRITE, 2'b11, $random(seed), 2);
        check_ptr(8'hc3);
        load_ptr(8'd10);
        issue(OP_READ, 2'b11, '0, 0); // write still landed at the old pointer
        end_test("load priority");

        tests++;
        if (lat_errors == 0)
            $display("latency: ok");
        else
            $display("latency: %0d errors", lat_errors);

        repeat (2) @(negedge clk);
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
design/sram_pkg.sv
design/sram_bus_if.sv
design/sram_cfg_regs.sv
design/sram_ctrl.sv
design/sram_array.sv
design/sram_top.sv
test/sram_tb.sv

//--- Bender.yml
package:
  name: sram_subsystem

sources:
  - design/sram_pkg.sv
  - design/sram_bus_if.sv
  - design/sram_cfg_regs.sv
  - design/sram_ctrl.sv
  - design/sram_array.sv
  - design/sram_top.sv
  - target: test
    files:
      - test/sram_tb.sv
